// File: flist.f
verilog/datapathPkg.sv
verilog/busArbiter.sv
verilog/registerFile.sv
verilog/alu.sv
verilog/memoryInterface.sv
verilog/fetchRegisters.sv
verilog/datapathTop.sv
testbench/datapathBus_assertions.sv
testbench/datapathChecker.sv
testbench/datapathTb.sv

// File: testbench/datapathTb.sv
`timescale 1ns/1ps
`default_nettype none

module datapathTb;
    import datapathPkg::*;

    localparam int dataWidth = 32;
    localparam int registerCount = 16;
    localparam int resetCycles = 16;
    localparam int rowCount = 12;
    localparam int stepsPerRow = 10;
    localparam int otherCycles = 32;    // Reset reads, fetch and conflict tests
    localparam int cycleLimit = resetCycles + rowCount * stepsPerRow + otherCycles + 40;
    localparam logic [dataWidth-1:0] fetchAddress = 32'h0000_0040;
    localparam logic [dataWidth-1:0] fetchWord = 32'h8B38_0000;    // neg R6, R7

    typedef struct packed {
        logic [8*16-1:0]      name;
        logic [dataWidth-1:0] operandA;
        logic [dataWidth-1:0] operandB;
        aluOp                 op;
        logic [dataWidth-1:0] expLow;
        logic [dataWidth-1:0] expHigh;
    } testRow;

    logic                     Clock;
    logic                     reset;
    controlWord               control;
    logic [registerCount-1:0] regIn;
    logic [registerCount-1:0] regOut;
    logic [dataWidth-1:0]     memoryData;
    logic [dataWidth-1:0]     busData;
    logic                     busConflict;
    logic [dataWidth-1:0]     memoryAddress;
    logic [dataWidth-1:0]     instruction;
    logic [2*dataWidth-1:0]   zValue;
    logic                     checkValid;
    logic [1:0]               checkSelect;
    logic [dataWidth-1:0]     expectedValue;
    logic                     expectedConflict;
    logic [8*16-1:0]          checkName;
    int                       valueErrors;
    int                       otherErrors;
    logic                     timedOut;
    testRow                   tests [rowCount];
    int                       rowIndex;

    datapathTop #(.dataWidth(dataWidth), .registerCount(registerCount)) uut (
        .Clock(Clock),
        .reset(reset),
        .control(control),
        .regIn(regIn),
        .regOut(regOut),
        .memoryData(memoryData),
        .busData(busData),
        .busConflict(busConflict),
        .memoryAddress(memoryAddress),
        .instruction(instruction),
        .zValue(zValue)
    );

    datapathChecker #(.dataWidth(dataWidth), .cycleLimit(cycleLimit)) resultChecker (
        .Clock(Clock),
        .busData(busData),
        .busConflict(busConflict),
        .memoryAddress(memoryAddress),
        .instruction(instruction),
        .checkValid(checkValid),
        .checkSelect(checkSelect),
        .expectedValue(expectedValue),
        .expectedConflict(expectedConflict),
        .checkName(checkName),
        .valueErrors(valueErrors),
        .otherErrors(otherErrors),
        .timedOut(timedOut)
    );

    bind datapathTop datapathBusAssertions #(
        .dataWidth(dataWidth),
        .registerCount(registerCount)
    ) busAssertions (
        .Clock(Clock),
        .reset(reset),
        .regOut(regOut),
        .control(control),
        .busData(busData),
        .busConflict(busConflict),
        .source(busSourceSel),
        .zValue(zValue)
    );

    always #10 Clock = ~Clock;

    function automatic controlWord idleWord();
        idleWord = '0;
        idleWord.op = opNop;
    endfunction

    function automatic logic [registerCount-1:0] registerSelect(input int index);
        registerSelect = '0;
        registerSelect[index] = 1'b1;
    endfunction

    task automatic addRow(input logic [8*16-1:0] name, input logic [dataWidth-1:0] a,
                          input logic [dataWidth-1:0] b, input aluOp op,
                          input logic [dataWidth-1:0] low, input logic [dataWidth-1:0] high);
        tests[rowIndex] = {name, a, b, op, low, high};
        rowIndex = rowIndex + 1;
    endtask

    task automatic buildTable();
        int                   seed;
        logic [dataWidth-1:0] a;
        logic [dataWidth-1:0] b;
        seed = 78;
        rowIndex = 0;
        addRow("add", 32'h1234_5678, 32'h1111_1111, opAdd, 32'h2345_6789, '0);
        addRow("sub", 32'h0000_0010, 32'h0000_0020, opSub, 32'hFFFF_FFF0, '0);
        addRow("and", 32'hF0F0_F0F0, 32'h0FF0_0FF0, opAnd, 32'h00F0_00F0, '0);
        addRow("or", 32'hF000_0000, 32'h0000_000F, opOr, 32'hF000_000F, '0);
        addRow("not", 32'h0000_0005, 32'h0000_FFFF, opNot, 32'hFFFF_0000, '0);
        addRow("shiftLeft", 32'h0000_0003, 32'd4, opShiftLeft, 32'h0000_0030, '0);
        addRow("shiftRight", 32'h8000_0000, 32'd31, opShiftRight, 32'h0000_0001, '0);
        addRow("neg", 32'h0000_0000, 32'h0000_0001, opNeg, 32'hFFFF_FFFF, '0);
        addRow("mulLarge", 32'h7FFF_FFFF, 32'h7FFF_FFFF, opMul, 32'h0000_0001, 32'h3FFF_FFFF);
        addRow("mulSigned", 32'hFFFF_FFFF, 32'h0000_0002, opMul, 32'hFFFF_FFFE, 32'hFFFF_FFFF);
        a = $random(seed);
        b = $random(seed);
        addRow("randomAdd", a, b, opAdd, a + b, '0);
        a = $random(seed);
        b = $random(seed);
        addRow("randomSub", a, b, opSub, a - b, '0);
    endtask

    // One bus transfer at the falling edge
    task automatic setInputs(input controlWord ctl, input logic [registerCount-1:0] inMask,
                             input logic [registerCount-1:0] outMask,
                             input logic [dataWidth-1:0] memWord);
        @(negedge Clock);
        control = ctl;
        regIn = inMask;
        regOut = outMask;
        memoryData = memWord;
        checkValid = 1'b0;
    endtask

    task automatic checkValue(input logic [1:0] sel, input controlWord ctl,
                              input logic [registerCount-1:0] outMask,
                              input logic [dataWidth-1:0] expected, input logic conflict,
                              input logic [8*16-1:0] name);
        setInputs(ctl, '0, outMask, '0);
        checkValid = 1'b1;
        checkSelect = sel;
        expectedValue = expected;
        expectedConflict = conflict;
        checkName = name;
    endtask

    // Memory word to MDR, then MDR to the register
    task automatic loadRegister(input int index, input logic [dataWidth-1:0] value);
        controlWord ctl;
        ctl = idleWord();
        ctl.read = 1'b1;
        ctl.mdrIn = 1'b1;
        setInputs(ctl, '0, '0, value);
        ctl = idleWord();
        ctl.mdrOut = 1'b1;
        setInputs(ctl, registerSelect(index), '0, '0);
    endtask

    task automatic runRow(input testRow row);
        controlWord ctl;
        loadRegister(6, row.operandA);
        loadRegister(7, row.operandB);
        ctl = idleWord();
        ctl.yIn = 1'b1;
        setInputs(ctl, '0, registerSelect(6), '0);
        ctl = idleWord();
        ctl.zIn = 1'b1;
        ctl.op = row.op;    // Z gets Y op R7
        setInputs(ctl, '0, registerSelect(7), '0);
        ctl = idleWord();
        ctl.zLowOut = 1'b1;
        setInputs(ctl, registerSelect(5), '0, '0);
        ctl = idleWord();
        ctl.zHighOut = 1'b1;
        ctl.hiIn = 1'b1;
        setInputs(ctl, '0, '0, '0);
        checkValue(2'd0, idleWord(), registerSelect(5), row.expLow, 1'b0, row.name);
        ctl = idleWord();
        ctl.hiOut = 1'b1;
        checkValue(2'd0, ctl, '0, row.expHigh, 1'b0, row.name);
    endtask

    task automatic fetchInstruction();
        controlWord ctl;
        ctl = idleWord();
        ctl.read = 1'b1;
        ctl.mdrIn = 1'b1;
        setInputs(ctl, '0, '0, fetchAddress);
        ctl = idleWord();
        ctl.mdrOut = 1'b1;
        ctl.pcIn = 1'b1;
        setInputs(ctl, '0, '0, '0);
        ctl = idleWord();    // T0
        ctl.pcOut = 1'b1;
        ctl.marIn = 1'b1;
        ctl.incPc = 1'b1;
        ctl.zIn = 1'b1;
        setInputs(ctl, '0, '0, '0);
        ctl = idleWord();    // T1
        ctl.zLowOut = 1'b1;
        ctl.pcIn = 1'b1;
        ctl.read = 1'b1;
        ctl.mdrIn = 1'b1;
        setInputs(ctl, '0, '0, fetchWord);
        ctl = idleWord();    // T2
        ctl.mdrOut = 1'b1;
        ctl.irIn = 1'b1;
        setInputs(ctl, '0, '0, '0);
        checkValue(2'd1, idleWord(), '0, fetchAddress, 1'b0, "fetchMar");
        checkValue(2'd2, idleWord(), '0, fetchWord, 1'b0, "fetchIr");
        ctl = idleWord();
        ctl.pcOut = 1'b1;
        checkValue(2'd0, ctl, '0, fetchAddress + 1, 1'b0, "fetchPc");
    endtask

    task automatic reportAndFinish();
        $display("Closing: %0d value errors, %0d other errors", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    initial begin
        controlWord ctl;
        Clock = 1'b0;
        reset = 1'b1;
        control = idleWord();
        regIn = '0;
        regOut = '0;
        memoryData = '0;
        checkValid = 1'b0;
        checkSelect = 2'd0;
        expectedValue = '0;
        expectedConflict = 1'b0;
        checkName = '0;
        buildTable();
        repeat (resetCycles) @(negedge Clock);
        reset = 1'b0;

        // Everything reads back zero after reset
        for (int i = 0; i < registerCount; i++) begin
            checkValue(2'd0, idleWord(), registerSelect(i), '0, 1'b0, "resetRegister");
        end
        ctl = idleWord();
        ctl.hiOut = 1'b1;
        checkValue(2'd0, ctl, '0, '0, 1'b0, "resetHi");
        ctl = idleWord();
        ctl.loOut = 1'b1;
        checkValue(2'd0, ctl, '0, '0, 1'b0, "resetLo");
        ctl = idleWord();
        ctl.pcOut = 1'b1;
        checkValue(2'd0, ctl, '0, '0, 1'b0, "resetPc");

        for (int i = 0; i < rowCount; i++) begin
            runRow(tests[i]);
        end
        fetchInstruction();

        // Two drivers at once, then one
        ctl = idleWord();
        ctl.pcOut = 1'b1;
        ctl.mdrOut = 1'b1;
        checkValue(2'd0, ctl, '0, '0, 1'b1, "conflict");
        ctl = idleWord();
        ctl.mdrOut = 1'b1;
        checkValue(2'd0, ctl, '0, fetchWord, 1'b0, "conflictClear");
        setInputs(idleWord(), '0, '0, '0);
        @(negedge Clock);
        reportAndFinish();
    end

    initial begin
        wait (timedOut === 1'b1);
        @(negedge Clock);
        reportAndFinish();
    end

endmodule

`default_nettype wire

// File: testbench/datapathChecker.sv
`timescale 1ns/1ps
`default_nettype none

module datapathChecker #(
    parameter int dataWidth = 32,
    parameter int cycleLimit = 1000
) (
    input  wire logic                 Clock,
    input  wire logic [dataWidth-1:0] busData,
    input  wire logic                 busConflict,
    input  wire logic [dataWidth-1:0] memoryAddress,
    input  wire logic [dataWidth-1:0] instruction,
    input  wire logic                 checkValid,
    input  wire logic [1:0]           checkSelect,     // 0 bus, 1 address, 2 IR
    input  wire logic [dataWidth-1:0] expectedValue,
    input  wire logic                 expectedConflict,
    input  wire logic [8*16-1:0]      checkName,
    output int                        valueErrors,
    output int                        otherErrors,
    output logic                      timedOut
);

    int                   cycleCount;
    logic [dataWidth-1:0] observed;

    initial begin
        valueErrors = 0;
        otherErrors = 0;
        timedOut = 1'b0;
        cycleCount = 0;
    end

    always_comb begin
        case (checkSelect)
            2'd1:    observed = memoryAddress;
            2'd2:    observed = instruction;
            default: observed = busData;
        endcase
    end

    // Sampled before the edge updates any register
    always @(posedge Clock) begin
        if (checkValid) begin
            if (observed !== expectedValue) begin
                $display("** Error %0s: expected %h, actual %h",
                         checkName, expectedValue, observed);
                valueErrors = valueErrors + 1;
            end
            if (busConflict !== expectedConflict) begin
                $display("** Error %0s conflict flag: expected %b, actual %b",
                         checkName, expectedConflict, busConflict);
                valueErrors = valueErrors + 1;
            end
        end
        cycleCount = cycleCount + 1;
        if (cycleCount == cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            otherErrors = otherErrors + 1;
            timedOut = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: testbench/datapathBus_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module datapathBusAssertions #(
    parameter int dataWidth = 32,
    parameter int registerCount = 16
) (
    input  wire logic                     Clock,
    input  wire logic                     reset,
    input  wire logic [registerCount-1:0] regOut,
    input  wire datapathPkg::controlWord  control,
    input  wire logic [dataWidth-1:0]     busData,
    input  wire logic                     busConflict,
    input  wire datapathPkg::busSource    source,
    input  wire logic [2*dataWidth-1:0]   zValue
);
    import datapathPkg::*;

    logic [registerCount+5:0] outStrobes;    // Every bus driver enable

    assign outStrobes = {regOut, control.hiOut, control.loOut, control.pcOut,
                         control.mdrOut, control.zLowOut, control.zHighOut};

    conflictMatchesStrobes: assert property (
        @(posedge Clock) busConflict == ($countones(outStrobes) > 1))
        else $error("Bus conflict flag disagrees with the number of out-strobes");

    idleBusIsZero: assert property (
        @(posedge Clock) (outStrobes == '0) |-> (busData == '0))
        else $error("Bus not zero with no driver enabled");

    // A single enabled driver always owns the bus
    loneDriverOwnsBus: assert property (
        @(posedge Clock) ($countones(outStrobes) == 1) |-> (source != srcNone))
        else $error("Bus has no owner although exactly one driver is enabled");

    zClearAfterReset: assert property (
        @(posedge Clock) $fell(reset) |-> (zValue == '0))
        else $error("Z register not cleared by reset");

endmodule

`default_nettype wire

// File: verilog/datapathTop.sv
`timescale 1ns/1ps
`default_nettype none

module datapathTop #(
    parameter int dataWidth = 32,
    parameter int registerCount = 16
) (
    input  wire logic                     Clock,
    input  wire logic                     reset,
    input  wire datapathPkg::controlWord  control,
    input  wire logic [registerCount-1:0] regIn,
    input  wire logic [registerCount-1:0] regOut,
    input  wire logic [dataWidth-1:0]     memoryData,
    output logic [dataWidth-1:0]          busData,
    output logic                          busConflict,
    output logic [dataWidth-1:0]          memoryAddress,
    output logic [dataWidth-1:0]          instruction,
    output logic [2*dataWidth-1:0]        zValue
);

    logic [dataWidth-1:0]  general;
    logic [dataWidth-1:0]  hiValue;
    logic [dataWidth-1:0]  loValue;
    logic [dataWidth-1:0]  pcValue;
    logic [dataWidth-1:0]  mdrValue;
    datapathPkg::busSource busSourceSel;    // Current bus owner

    busArbiter #(.dataWidth(dataWidth), .registerCount(registerCount)) arbiter (
        .regOut(regOut),
        .general(general),
        .control(control),
        .hiValue(hiValue),
        .loValue(loValue),
        .pcValue(pcValue),
        .mdrValue(mdrValue),
        .zValue(zValue),
        .busData(busData),
        .busConflict(busConflict),
        .source(busSourceSel)
    );

    registerFile #(.dataWidth(dataWidth), .registerCount(registerCount)) registers (
        .Clock(Clock),
        .reset(reset),
        .busData(busData),
        .regIn(regIn),
        .regOut(regOut),
        .control(control),
        .general(general),
        .hiValue(hiValue),
        .loValue(loValue)
    );

    alu #(.dataWidth(dataWidth)) aluUnit (
        .Clock(Clock),
        .reset(reset),
        .busData(busData),
        .control(control),
        .zValue(zValue)
    );

    memoryInterface #(.dataWidth(dataWidth)) memory (
        .Clock(Clock),
        .reset(reset),
        .busData(busData),
        .memoryData(memoryData),
        .control(control),
        .mdrValue(mdrValue),
        .memoryAddress(memoryAddress)
    );

    fetchRegisters #(.dataWidth(dataWidth)) fetch (
        .Clock(Clock),
        .reset(reset),
        .busData(busData),
        .control(control),
        .pcValue(pcValue),
        .instruction(instruction)
    );

endmodule

`default_nettype wire

// File: verilog/fetchRegisters.sv
`timescale 1ns/1ps
`default_nettype none

module fetchRegisters #(
    parameter int dataWidth = 32
) (
    input  wire logic                    Clock,
    input  wire logic                    reset,
    input  wire logic [dataWidth-1:0]    busData,
    input  wire datapathPkg::controlWord control,
    output logic [dataWidth-1:0]         pcValue,
    output logic [dataWidth-1:0]         instruction
);

    // PC is incremented through Z, so it only loads from the bus
    always_ff @(posedge Clock) begin
        if (reset) begin
            pcValue <= '0;
        end else if (control.pcIn) begin
            pcValue <= busData;
        end
    end

    // IR layout: opcode in the top five bits, then Ra, Rb and Rc at four bits each,
    // with the constant field below them
    always_ff @(posedge Clock) begin
        if (reset) begin
            instruction <= '0;
        end else if (control.irIn) begin
            instruction <= busData;
        end
    end

endmodule

`default_nettype wire

// File: verilog/memoryInterface.sv
`timescale 1ns/1ps
`default_nettype none

module memoryInterface #(
    parameter int dataWidth = 32
) (
    input  wire logic                    Clock,
    input  wire logic                    reset,
    input  wire logic [dataWidth-1:0]    busData,
    input  wire logic [dataWidth-1:0]    memoryData,
    input  wire datapathPkg::controlWord control,
    output logic [dataWidth-1:0]         mdrValue,
    output logic [dataWidth-1:0]         memoryAddress
);

    logic [dataWidth-1:0] mdrNext;

    // Read selects memory data, otherwise the bus
    assign mdrNext = control.read ? memoryData : busData;

    always_ff @(posedge Clock) begin
        if (reset) begin
            mdrValue <= '0;
        end else if (control.mdrIn) begin
            mdrValue <= mdrNext;
        end
    end

    // MAR drives the address straight out
    always_ff @(posedge Clock) begin
        if (reset) begin
            memoryAddress <= '0;
        end else if (control.marIn) begin
            memoryAddress <= busData;
        end
    end

endmodule

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu #(
    parameter int dataWidth = 32
) (
    input  wire logic                    Clock,
    input  wire logic                    reset,
    input  wire logic [dataWidth-1:0]    busData,
    input  wire datapathPkg::controlWord control,
    output logic [2*dataWidth-1:0]       zValue
);
    import datapathPkg::*;

    localparam int shiftBits = $clog2(dataWidth);

    logic [dataWidth-1:0]          yReg;
    logic [dataWidth-1:0]          lowResult;
    logic signed [2*dataWidth-1:0] product;
    logic [2*dataWidth-1:0]        zNext;
    logic [shiftBits-1:0]          shiftAmount;

    // Shift distance comes from the low bits of the bus
    assign shiftAmount = busData[shiftBits-1:0];

    // Signed multiply, both operands sign extended to full width
    assign product = $signed(yReg) * $signed(busData);

    // Single-width operations, always Y op bus
    always_comb begin
        case (control.op)
            opAdd:        lowResult = yReg + busData;
            opSub:        lowResult = yReg - busData;
            opAnd:        lowResult = yReg & busData;
            opOr:         lowResult = yReg | busData;
            opShiftLeft:  lowResult = yReg << shiftAmount;
            opShiftRight: lowResult = yReg >> shiftAmount;    // Logical
            opNeg:        lowResult = -busData;                // Bus only
            opNot:        lowResult = ~busData;                // Bus only
            default:      lowResult = '0;
        endcase
    end

    always_comb begin
        zNext = zValue;
        if (control.incPc) begin
            // PC increment path overrides the opcode
            zNext = {{dataWidth{1'b0}}, busData + dataWidth'(1)};
        end else if (control.op == opMul) begin
            zNext = product;
        end else if (control.op != opNop) begin
            zNext = {{dataWidth{1'b0}}, lowResult};
        end
    end

    always_ff @(posedge Clock) begin
        if (reset) begin
            yReg <= '0;
        end else if (control.yIn) begin
            yReg <= busData;
        end
    end

    always_ff @(posedge Clock) begin
        if (reset) begin
            zValue <= '0;
        end else if (control.zIn) begin
            zValue <= zNext;
        end
    end

endmodule

`default_nettype wire

// File: verilog/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile #(
    parameter int dataWidth = 32,
    parameter int registerCount = 16
) (
    input  wire logic                     Clock,
    input  wire logic                     reset,
    input  wire logic [dataWidth-1:0]     busData,
    input  wire logic [registerCount-1:0] regIn,
    input  wire logic [registerCount-1:0] regOut,
    input  wire datapathPkg::controlWord  control,
    output logic [dataWidth-1:0]          general,
    output logic [dataWidth-1:0]          hiValue,
    output logic [dataWidth-1:0]          loValue
);

    logic [dataWidth-1:0] registers [registerCount];

    always_ff @(posedge Clock) begin
        if (reset) begin
            for (int i = 0; i < registerCount; i++) begin
                registers[i] <= '0;
            end
            hiValue <= '0;
            loValue <= '0;
        end else begin
            // Several registers may load the same bus value
            for (int i = 0; i < registerCount; i++) begin
                if (regIn[i]) begin
                    registers[i] <= busData;
                end
            end
            if (control.hiIn) hiValue <= busData;
            if (control.loIn) loValue <= busData;
        end
    end

    // Lowest set out-strobe wins here; the arbiter flags multiples
    always_comb begin
        general = '0;
        for (int i = registerCount - 1; i >= 0; i--) begin
            if (regOut[i]) begin
                general = registers[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/busArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module busArbiter #(
    parameter int dataWidth = 32,
    parameter int registerCount = 16
) (
    input  wire logic [registerCount-1:0] regOut,
    input  wire logic [dataWidth-1:0]     general,
    input  wire datapathPkg::controlWord  control,
    input  wire logic [dataWidth-1:0]     hiValue,
    input  wire logic [dataWidth-1:0]     loValue,
    input  wire logic [dataWidth-1:0]     pcValue,
    input  wire logic [dataWidth-1:0]     mdrValue,
    input  wire logic [2*dataWidth-1:0]   zValue,
    output logic [dataWidth-1:0]          busData,
    output logic                          busConflict,
    output datapathPkg::busSource         source
);
    import datapathPkg::*;

    // Wide enough for every register strobe plus the six others
    localparam int countWidth = $clog2(registerCount + 7);

    logic [countWidth-1:0] activeCount;

    always_comb begin
        activeCount = '0;
        for (int i = 0; i < registerCount; i++) begin
            activeCount = activeCount + countWidth'(regOut[i]);
        end
        activeCount = activeCount + countWidth'(control.hiOut) + countWidth'(control.loOut);
        activeCount = activeCount + countWidth'(control.pcOut) + countWidth'(control.mdrOut);
        activeCount = activeCount + countWidth'(control.zLowOut)
                    + countWidth'(control.zHighOut);
    end

    assign busConflict = activeCount > countWidth'(1);

    // Only a lone driver gets a source code
    always_comb begin
        source = srcNone;
        if (activeCount == countWidth'(1)) begin
            if (|regOut)                 source = srcGeneral;
            else if (control.hiOut)      source = srcHi;
            else if (control.loOut)      source = srcLo;
            else if (control.pcOut)      source = srcPc;
            else if (control.mdrOut)     source = srcMdr;
            else if (control.zLowOut)    source = srcZLow;
            else                         source = srcZHigh;
        end
    end

    always_comb begin
        case (source)
            srcGeneral: busData = general;
            srcHi:      busData = hiValue;
            srcLo:      busData = loValue;
            srcPc:      busData = pcValue;
            srcMdr:     busData = mdrValue;
            srcZLow:    busData = zValue[dataWidth-1:0];
            srcZHigh:   busData = zValue[2*dataWidth-1:dataWidth];
            default:    busData = '0;    // Idle or conflict
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/datapathPkg.sv
`default_nettype none

package datapathPkg;

    // ALU operation codes; neg and nop match the reference encoding
    typedef enum logic [4:0] {
        opAdd        = 5'b00011,
        opSub        = 5'b00100,
        opAnd        = 5'b00101,
        opOr         = 5'b00110,
        opShiftRight = 5'b00111,
        opShiftLeft  = 5'b01000,
        opNop        = 5'b01101,
        opMul        = 5'b01111,
        opNeg        = 5'b10001,
        opNot        = 5'b10010
    } aluOp;

    // Non-register strobes, one cycle each
    typedef struct packed {
        logic pcOut;
        logic pcIn;
        logic incPc;     // Z gets bus plus one
        logic mdrOut;
        logic mdrIn;
        logic read;      // MDR takes memory data instead of bus
        logic marIn;
        logic irIn;
        logic yIn;
        logic zIn;
        logic zLowOut;
        logic zHighOut;
        logic hiOut;
        logic hiIn;
        logic loOut;
        logic loIn;
        aluOp op;
    } controlWord;

    // Which unit currently owns the bus
    typedef enum logic [2:0] {
        srcNone,
        srcGeneral,
        srcHi,
        srcLo,
        srcPc,
        srcMdr,
        srcZLow,
        srcZHigh
    } busSource;

endpackage

`default_nettype wire
